//--- te_pkg.sv
// widths, pass phase enum, config, FIFO entry and GLB request types
package te_pkg;

    localparam int GLB_AW = 32;  // word address
    localparam int GLB_DW = 32;

    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,
        INIT_FIFO,
        PREHEAT,
        NORMAL_LOOP,
        DONE
    } te_phase_e;

    typedef struct packed {
        logic [GLB_AW-1:0] weight_base;
        logic [GLB_AW-1:0] ifmap_base;
        logic [GLB_AW-1:0] ipsum_base;
        logic [GLB_AW-1:0] bias_base;
        logic [GLB_AW-1:0] opsum_base;
        logic [7:0]        tile_len;   // elements per lane
        logic              is_bias;
    } pass_cfg_t;

    typedef struct packed {
        logic [7:0] act;  // low byte of the GLB word
    } ifmap_entry_t;

    // shared by ipsum and opsum FIFOs
    typedef struct packed {
        logic [GLB_DW-1:0] psum;
    } psum_entry_t;

    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [GLB_AW-1:0] addr;
        logic [GLB_DW-1:0] wdata;
        logic [3:0]        web;
    } glb_req_t;

    typedef enum logic [1:0] {WEIGHT, OPSUM, IPSUM, IFMAP} glb_src_e;

endpackage

//--- lane_fifo.sv
// lane FIFO with generic payload and one credit pulse per pop
`timescale 1ns/1ps

module lane_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     clear_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o,
    output logic     credit_o
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr, rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty_o    = (count == '0);
    assign do_pop     = pop_i && !empty_o;
    assign pop_data_o = mem[rd_ptr];  // head always visible

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else if (clear_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count    <= count + CW'(push_i) - CW'(do_pop);
            credit_o <= do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr] <= push_data_i;
    end

endmodule

//--- pass_controller.sv
// pass phase FSM with pass done pulse
`timescale 1ns/1ps

module pass_controller
    import te_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      pass_start_i,
    input  logic      weight_done_i,
    input  logic      preheat_done_i,
    input  logic      loop_done_i,
    output te_phase_e phase_o,
    output logic      pass_done_o
);

    te_phase_e phase_d;

    always_comb begin
        phase_d = phase_o;
        case (phase_o)
            IDLE: begin
                if (pass_start_i) phase_d = WEIGHT_LOAD;
            end
            WEIGHT_LOAD: begin
                if (weight_done_i) phase_d = INIT_FIFO;
            end
            INIT_FIFO: phase_d = PREHEAT;  // single clear cycle
            PREHEAT: begin
                if (preheat_done_i) phase_d = NORMAL_LOOP;
            end
            NORMAL_LOOP: begin
                if (loop_done_i) phase_d = DONE;
            end
            default: phase_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_o <= IDLE;
        end else begin
            phase_o <= phase_d;
        end
    end

    // last opsum write already counted by the drain
    assign pass_done_o = (phase_o == NORMAL_LOOP) && loop_done_i;

endmodule

//--- weight_loader.sv
// weight fetch, one GLB word per lane, and lane weight registers
`timescale 1ns/1ps

module weight_loader
    import te_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  te_phase_e                     phase_i,
    input  pass_cfg_t                     cfg_i,
    input  logic                          gnt_i,
    input  logic                          rd_valid_i,
    input  logic [GLB_DW-1:0]             rd_data_i,
    output glb_req_t                      req_o,
    output logic                          req_valid_o,
    output ifmap_entry_t [NUM_LANES-1:0]  weights_o,
    output logic                          done_o
);

    localparam int IW = $clog2(NUM_LANES + 1);

    logic [IW-1:0] req_idx;  // next lane to request
    logic [IW-1:0] ret_idx;  // next lane to fill

    assign req_valid_o = (phase_i == WEIGHT_LOAD) && (req_idx < IW'(NUM_LANES));
    assign req_o = '{rd: 1'b1, wr: 1'b0, addr: cfg_i.weight_base + GLB_AW'(req_idx),
                     wdata: '0, web: '0};
    assign done_o = (ret_idx == IW'(NUM_LANES));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_idx <= '0;
            ret_idx <= '0;
        end else if (phase_i == IDLE) begin
            req_idx <= '0;
            ret_idx <= '0;
        end else begin
            if (gnt_i) req_idx <= req_idx + 1'b1;
            if (rd_valid_i) ret_idx <= ret_idx + 1'b1;
        end
    end

    // returns come back in request order
    always_ff @(posedge clk) begin
        if (rd_valid_i) weights_o[ret_idx] <= '{act: rd_data_i[7:0]};
    end

endmodule

//--- fifo_fill_ctrl.sv
// ifmap and ipsum/bias read issue under credit, return routing to lane FIFOs
`timescale 1ns/1ps

module fifo_fill_ctrl
    import te_pkg::*;
#(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  te_phase_e            phase_i,
    input  pass_cfg_t            cfg_i,
    input  logic                 gnt_i,
    input  logic                 rd_valid_i,
    input  glb_src_e             rd_src_i,
    input  logic [GLB_DW-1:0]    rd_data_i,
    input  logic [NUM_LANES-1:0] ifmap_credit_i,
    input  logic [NUM_LANES-1:0] ipsum_credit_i,
    output logic [NUM_LANES-1:0] ifmap_push_o,
    output logic [NUM_LANES-1:0] ipsum_push_o,
    output ifmap_entry_t         ifmap_data_o,
    output psum_entry_t          ipsum_data_o,
    output glb_req_t             req_o,
    output logic                 req_valid_o,
    output glb_src_e             req_src_o,
    output logic                 preheat_done_o
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0][CW-1:0] if_cred, ip_cred;
    logic [NUM_LANES-1:0][7:0]    if_cnt, ip_cnt;   // words issued per lane
    logic [NUM_LANES-1:0]         if_ok, ip_ok, lane_full;
    logic [LW-1:0]                rr, sel, req_lane, tag_lane;
    logic                         found, sel_ip, take;
    logic [GLB_AW-1:0]            lane_off, next_addr;

    always_comb begin
        found  = 1'b0;
        sel_ip = 1'b0;
        sel    = rr;
        for (int l = 0; l < NUM_LANES; l++) begin
            if_ok[l] = (phase_i == PREHEAT || phase_i == NORMAL_LOOP) && (if_cred[l] != '0)
                       && (if_cnt[l] < cfg_i.tile_len);
            ip_ok[l] = (phase_i == NORMAL_LOOP) && (ip_cred[l] != '0)
                       && (ip_cnt[l] < cfg_i.tile_len);
            lane_full[l] = (if_cred[l] == '0) || (if_cnt[l] == cfg_i.tile_len);
        end
        // ipsum scan runs last and so wins over ifmap
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (if_ok[(int'(rr) + k) % NUM_LANES]) begin
                found = 1'b1;
                sel   = LW'((int'(rr) + k) % NUM_LANES);
            end
        end
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (ip_ok[(int'(rr) + k) % NUM_LANES]) begin
                found  = 1'b1;
                sel_ip = 1'b1;
                sel    = LW'((int'(rr) + k) % NUM_LANES);
            end
        end
        lane_off = GLB_AW'(sel) * GLB_AW'(cfg_i.tile_len);
        if (!sel_ip) next_addr = cfg_i.ifmap_base + lane_off + GLB_AW'(if_cnt[sel]);
        else if (cfg_i.is_bias) next_addr = cfg_i.bias_base + GLB_AW'(sel);  // same bias per element
        else next_addr = cfg_i.ipsum_base + lane_off + GLB_AW'(ip_cnt[sel]);
    end

    assign take           = found && (!req_valid_o || gnt_i);
    assign preheat_done_o = (phase_i == PREHEAT) && (&lane_full);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_cred     <= '0;
            ip_cred     <= '0;
            if_cnt      <= '0;
            ip_cnt      <= '0;
            rr          <= '0;
            req_valid_o <= 1'b0;
            req_lane    <= '0;
            req_src_o   <= IFMAP;
            tag_lane    <= '0;
        end else if (phase_i == INIT_FIFO) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if_cred[l] <= CW'(FIFO_DEPTH);
                ip_cred[l] <= CW'(FIFO_DEPTH);
            end
            if_cnt      <= '0;
            ip_cnt      <= '0;
            rr          <= '0;
            req_valid_o <= 1'b0;
        end else begin
            // credit reserved when the read is queued
            for (int l = 0; l < NUM_LANES; l++) begin
                if_cred[l] <= if_cred[l] + CW'(ifmap_credit_i[l])
                              - CW'(take && !sel_ip && sel == LW'(l));
                ip_cred[l] <= ip_cred[l] + CW'(ipsum_credit_i[l])
                              - CW'(take && sel_ip && sel == LW'(l));
                if_cnt[l]  <= if_cnt[l] + 8'(take && !sel_ip && sel == LW'(l));
                ip_cnt[l]  <= ip_cnt[l] + 8'(take && sel_ip && sel == LW'(l));
            end
            if (gnt_i) tag_lane <= req_lane;  // data returns next cycle
            if (take) begin
                req_valid_o <= 1'b1;
                req_lane    <= sel;
                req_src_o   <= sel_ip ? IPSUM : IFMAP;
                rr          <= LW'((int'(sel) + 1) % NUM_LANES);
            end else if (gnt_i) begin
                req_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) req_o <= '{rd: 1'b1, wr: 1'b0, addr: next_addr, wdata: '0, web: '0};
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            ifmap_push_o[l] = rd_valid_i && (rd_src_i == IFMAP) && (tag_lane == LW'(l));
            ipsum_push_o[l] = rd_valid_i && (rd_src_i == IPSUM) && (tag_lane == LW'(l));
        end
    end

    assign ifmap_data_o = '{act: rd_data_i[7:0]};
    assign ipsum_data_o = '{psum: rd_data_i};

endmodule

//--- mac_lane_array.sv
// per-lane multiply-accumulate with opsum credit tracking
`timescale 1ns/1ps

module mac_lane_array
    import te_pkg::*;
#(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  te_phase_e                    phase_i,
    input  ifmap_entry_t [NUM_LANES-1:0] weights_i,
    input  ifmap_entry_t [NUM_LANES-1:0] ifmap_head_i,
    input  psum_entry_t  [NUM_LANES-1:0] ipsum_head_i,
    input  logic         [NUM_LANES-1:0] ifmap_empty_i,
    input  logic         [NUM_LANES-1:0] ipsum_empty_i,
    input  logic         [NUM_LANES-1:0] opsum_credit_i,
    output logic         [NUM_LANES-1:0] ifmap_pop_o,
    output logic         [NUM_LANES-1:0] ipsum_pop_o,
    output logic         [NUM_LANES-1:0] opsum_push_o,
    output psum_entry_t  [NUM_LANES-1:0] opsum_data_o
);

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [NUM_LANES-1:0][CW-1:0] op_cred;
    logic [NUM_LANES-1:0]         fire;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            fire[l] = (phase_i == NORMAL_LOOP) && !ifmap_empty_i[l] && !ipsum_empty_i[l]
                      && (op_cred[l] != '0);
        end
    end

    assign ifmap_pop_o = fire;
    assign ipsum_pop_o = fire;  // both heads consumed together

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            op_cred      <= '0;
            opsum_push_o <= '0;
        end else if (phase_i == INIT_FIFO) begin
            for (int l = 0; l < NUM_LANES; l++) op_cred[l] <= CW'(FIFO_DEPTH);
            opsum_push_o <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                op_cred[l] <= op_cred[l] + CW'(opsum_credit_i[l]) - CW'(fire[l]);
            end
            opsum_push_o <= fire;
        end
    end

    // unsigned weight times activation
    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            if (fire[l]) begin
                opsum_data_o[l] <= '{psum: GLB_DW'(weights_i[l].act) * GLB_DW'(ifmap_head_i[l].act)
                                           + ipsum_head_i[l].psum};
            end
        end
    end

endmodule

//--- opsum_drain.sv
// round-robin opsum write-back and write count for loop done
`timescale 1ns/1ps

module opsum_drain
    import te_pkg::*;
#(
    parameter int NUM_LANES = 4
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  te_phase_e                   phase_i,
    input  pass_cfg_t                   cfg_i,
    input  psum_entry_t [NUM_LANES-1:0] heads_i,
    input  logic        [NUM_LANES-1:0] empty_i,
    input  logic                        gnt_i,
    output logic        [NUM_LANES-1:0] pop_o,
    output glb_req_t                    req_o,
    output logic                        req_valid_o,
    output logic                        done_o
);

    localparam int LW = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [NUM_LANES-1:0][7:0] elem_cnt;
    logic [15:0]               wr_cnt;
    logic [LW-1:0]             rr, pick, sel, lock_lane;
    logic                      any, locked;

    always_comb begin
        any  = 1'b0;
        pick = rr;
        for (int k = NUM_LANES - 1; k >= 0; k--) begin
            if (!empty_i[(int'(rr) + k) % NUM_LANES]) begin
                any  = 1'b1;
                pick = LW'((int'(rr) + k) % NUM_LANES);
            end
        end
        for (int l = 0; l < NUM_LANES; l++) pop_o[l] = gnt_i && (sel == LW'(l));
    end

    assign sel         = locked ? lock_lane : pick;  // stalled request stays on its lane
    assign req_valid_o = (phase_i == NORMAL_LOOP) && (locked || any);
    assign req_o = '{rd: 1'b0, wr: 1'b1,
                     addr: cfg_i.opsum_base + GLB_AW'(sel) * GLB_AW'(cfg_i.tile_len)
                           + GLB_AW'(elem_cnt[sel]),
                     wdata: heads_i[sel].psum, web: 4'hf};
    assign done_o = (phase_i == NORMAL_LOOP) && (wr_cnt == 16'(NUM_LANES) * 16'(cfg_i.tile_len));

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            elem_cnt  <= '0;
            wr_cnt    <= '0;
            rr        <= '0;
            locked    <= 1'b0;
            lock_lane <= '0;
        end else if (phase_i == INIT_FIFO) begin
            elem_cnt <= '0;
            wr_cnt   <= '0;
            rr       <= '0;
            locked   <= 1'b0;
        end else begin
            locked    <= req_valid_o && !gnt_i;
            lock_lane <= sel;
            if (gnt_i) begin
                elem_cnt[sel] <= elem_cnt[sel] + 1'b1;
                wr_cnt        <= wr_cnt + 1'b1;
                rr            <= LW'((int'(sel) + 1) % NUM_LANES);
            end
        end
    end

endmodule

//--- glb_arbiter.sv
// fixed priority GLB token arbiter with read return steering
`timescale 1ns/1ps

module glb_arbiter
    import te_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  glb_req_t          wl_req_i,
    input  logic              wl_valid_i,
    input  glb_req_t          drain_req_i,
    input  logic              drain_valid_i,
    input  glb_req_t          fill_req_i,
    input  logic              fill_valid_i,
    input  glb_src_e          fill_src_i,
    input  logic              glb_stall_i,
    input  logic [GLB_DW-1:0] glb_read_data_i,
    output glb_req_t          glb_req_o,
    output logic              wl_gnt_o,
    output logic              drain_gnt_o,
    output logic              fill_gnt_o,
    output logic              wl_rd_valid_o,
    output logic              fill_rd_valid_o,
    output glb_src_e          rd_src_o,
    output logic [GLB_DW-1:0] rd_data_o
);

    glb_src_e cur_src;
    logic     rd_pending;  // read accepted last cycle

    // weight, then opsum write, then fill (ipsum before ifmap inside fill)
    always_comb begin
        glb_req_o   = '0;
        cur_src     = WEIGHT;
        wl_gnt_o    = 1'b0;
        drain_gnt_o = 1'b0;
        fill_gnt_o  = 1'b0;
        if (wl_valid_i) begin
            glb_req_o = wl_req_i;
            wl_gnt_o  = !glb_stall_i;
        end else if (drain_valid_i) begin
            glb_req_o   = drain_req_i;
            cur_src     = OPSUM;
            drain_gnt_o = !glb_stall_i;
        end else if (fill_valid_i) begin
            glb_req_o  = fill_req_i;
            cur_src    = fill_src_i;
            fill_gnt_o = !glb_stall_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_pending <= 1'b0;
            rd_src_o   <= WEIGHT;
        end else begin
            rd_pending <= glb_req_o.rd && !glb_stall_i;
            rd_src_o   <= cur_src;
        end
    end

    assign wl_rd_valid_o   = rd_pending && (rd_src_o == WEIGHT);
    assign fill_rd_valid_o = rd_pending && (rd_src_o == IPSUM || rd_src_o == IFMAP);
    assign rd_data_o       = glb_read_data_i;

endmodule

//--- token_engine.sv
// token engine top: controller, input side, lanes, output side
`timescale 1ns/1ps

module token_engine
    import te_pkg::*;
#(
    parameter int NUM_LANES  = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              pass_start_i,
    input  pass_cfg_t         pass_cfg_i,
    input  logic              glb_stall_i,
    input  logic [GLB_DW-1:0] glb_read_data_i,
    output logic              pass_done_o,
    output glb_req_t          glb_req_o
);

    pass_cfg_t                    cfg_q;
    te_phase_e                    phase;
    logic                         weight_done, preheat_done, loop_done;
    glb_req_t                     wl_req, fill_req, drain_req;
    logic                         wl_valid, fill_valid, drain_valid;
    logic                         wl_gnt, fill_gnt, drain_gnt;
    logic                         wl_rd_valid, fill_rd_valid;
    glb_src_e                     fill_src, rd_src;
    logic [GLB_DW-1:0]            rd_data;
    ifmap_entry_t [NUM_LANES-1:0] weights, ifmap_head;
    ifmap_entry_t                 ifmap_wdata;
    psum_entry_t                  ipsum_wdata;
    psum_entry_t  [NUM_LANES-1:0] ipsum_head, opsum_head, opsum_wdata;
    logic [NUM_LANES-1:0]         ifmap_push, ifmap_pop, ifmap_empty, ifmap_credit;
    logic [NUM_LANES-1:0]         ipsum_push, ipsum_pop, ipsum_empty, ipsum_credit;
    logic [NUM_LANES-1:0]         opsum_push, opsum_pop, opsum_empty, opsum_credit;

    always_ff @(posedge clk) begin
        if (pass_start_i && phase == IDLE) cfg_q <= pass_cfg_i;
    end

    pass_controller u_ctrl (
        .clk, .rst_n_i, .pass_start_i, .weight_done_i(weight_done),
        .preheat_done_i(preheat_done), .loop_done_i(loop_done),
        .phase_o(phase), .pass_done_o
    );

    weight_loader #(.NUM_LANES(NUM_LANES)) u_wl (
        .clk, .rst_n_i, .phase_i(phase), .cfg_i(cfg_q), .gnt_i(wl_gnt),
        .rd_valid_i(wl_rd_valid), .rd_data_i(rd_data), .req_o(wl_req),
        .req_valid_o(wl_valid), .weights_o(weights), .done_o(weight_done)
    );

    fifo_fill_ctrl #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_fill (
        .clk, .rst_n_i, .phase_i(phase), .cfg_i(cfg_q), .gnt_i(fill_gnt),
        .rd_valid_i(fill_rd_valid), .rd_src_i(rd_src), .rd_data_i(rd_data),
        .ifmap_credit_i(ifmap_credit), .ipsum_credit_i(ipsum_credit),
        .ifmap_push_o(ifmap_push), .ipsum_push_o(ipsum_push),
        .ifmap_data_o(ifmap_wdata), .ipsum_data_o(ipsum_wdata), .req_o(fill_req),
        .req_valid_o(fill_valid), .req_src_o(fill_src), .preheat_done_o(preheat_done)
    );

    glb_arbiter u_arb (
        .clk, .rst_n_i, .wl_req_i(wl_req), .wl_valid_i(wl_valid),
        .drain_req_i(drain_req), .drain_valid_i(drain_valid), .fill_req_i(fill_req),
        .fill_valid_i(fill_valid), .fill_src_i(fill_src), .glb_stall_i, .glb_read_data_i,
        .glb_req_o, .wl_gnt_o(wl_gnt), .drain_gnt_o(drain_gnt), .fill_gnt_o(fill_gnt),
        .wl_rd_valid_o(wl_rd_valid), .fill_rd_valid_o(fill_rd_valid),
        .rd_src_o(rd_src), .rd_data_o(rd_data)
    );

    mac_lane_array #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_lanes (
        .clk, .rst_n_i, .phase_i(phase), .weights_i(weights), .ifmap_head_i(ifmap_head),
        .ipsum_head_i(ipsum_head), .ifmap_empty_i(ifmap_empty), .ipsum_empty_i(ipsum_empty),
        .opsum_credit_i(opsum_credit), .ifmap_pop_o(ifmap_pop), .ipsum_pop_o(ipsum_pop),
        .opsum_push_o(opsum_push), .opsum_data_o(opsum_wdata)
    );

    opsum_drain #(.NUM_LANES(NUM_LANES)) u_drain (
        .clk, .rst_n_i, .phase_i(phase), .cfg_i(cfg_q), .heads_i(opsum_head),
        .empty_i(opsum_empty), .gnt_i(drain_gnt), .pop_o(opsum_pop),
        .req_o(drain_req), .req_valid_o(drain_valid), .done_o(loop_done)
    );

    // three FIFOs per lane, all cleared in INIT_FIFO
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        lane_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(ifmap_entry_t)) u_ifmap_fifo (
            .clk, .rst_n_i, .clear_i(phase == INIT_FIFO), .push_i(ifmap_push[l]),
            .push_data_i(ifmap_wdata), .pop_i(ifmap_pop[l]), .pop_data_o(ifmap_head[l]),
            .empty_o(ifmap_empty[l]), .credit_o(ifmap_credit[l])
        );
        lane_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(psum_entry_t)) u_ipsum_fifo (
            .clk, .rst_n_i, .clear_i(phase == INIT_FIFO), .push_i(ipsum_push[l]),
            .push_data_i(ipsum_wdata), .pop_i(ipsum_pop[l]), .pop_data_o(ipsum_head[l]),
            .empty_o(ipsum_empty[l]), .credit_o(ipsum_credit[l])
        );
        lane_fifo #(.DEPTH(FIFO_DEPTH), .payload_t(psum_entry_t)) u_opsum_fifo (
            .clk, .rst_n_i, .clear_i(phase == INIT_FIFO), .push_i(opsum_push[l]),
            .push_data_i(opsum_wdata[l]), .pop_i(opsum_pop[l]), .pop_data_o(opsum_head[l]),
            .empty_o(opsum_empty[l]), .credit_o(opsum_credit[l])
        );
    end

endmodule

//--- tb_token_engine.sv
// testbench with clock, reset, GLB model, golden file reader, checks and timeout
`timescale 1ns/1ps

module tb_token_engine
    import te_pkg::*;
();

    localparam int NUM_LANES  = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int MW         = 8;  // model address bits
    localparam int MEM_WORDS  = 1 << MW;
    localparam int SEED       = 69084;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              pass_start_i;
    pass_cfg_t         pass_cfg_i;
    logic              glb_stall_i = 1'b0;
    logic [GLB_DW-1:0] glb_read_data_i = '0;
    logic              pass_done_o;
    glb_req_t          glb_req_o;

    logic [GLB_DW-1:0] mem       [MEM_WORDS];
    logic [GLB_DW-1:0] init_mem  [MEM_WORDS];  // preload image and reference snapshot
    logic [GLB_DW-1:0] exp_words [MEM_WORDS];
    logic              load_req;
    logic              stall_en;
    int                done_cnt = 0;
    int                cycles = 0;
    int                cycle_limit = 64;  // reset and first preload
    int                range_errs = 0;
    int                errors, tests_run, tests_failed, passes;

    always #5 clk = ~clk;

    token_engine #(.NUM_LANES(NUM_LANES), .FIFO_DEPTH(FIFO_DEPTH)) u_dut (
        .clk, .rst_n_i, .pass_start_i, .pass_cfg_i, .glb_stall_i, .glb_read_data_i,
        .pass_done_o, .glb_req_o
    );

    // GLB model with writes on accept and read data one cycle later
    initial begin
        logic [MW-1:0] idx;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            idx = glb_req_o.addr[MW-1:0];
            if (load_req) begin
                for (int a = 0; a < MEM_WORDS; a++) mem[a] = init_mem[a];
            end else if ((glb_req_o.rd || glb_req_o.wr) && !glb_stall_i) begin
                if (glb_req_o.addr >= 32'(MEM_WORDS)) begin
                    $display("GLB access to address %0h lies outside the model memory",
                             glb_req_o.addr);
                    range_errs = range_errs + 1;
                end else if (glb_req_o.wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (glb_req_o.web[b]) mem[idx][8*b +: 8] = glb_req_o.wdata[8*b +: 8];
                    end
                end else begin
                    glb_read_data_i <= mem[idx];
                end
            end
            glb_stall_i <= stall_en && ($urandom % 2 == 0);  // about half the cycles
        end
    end

    always @(posedge clk) begin
        if (pass_done_o) done_cnt <= done_cnt + 1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_value(input logic [8*24-1:0] test, input string what,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            $display("MISMATCH %0s %0s: expected %08h, actual %08h",
                     test, what, exp_val, act_val);
            errors++;
        end
    endtask

    // background pattern built from the whole address
    task automatic fill_background();
        for (int a = 0; a < MEM_WORDS; a++) begin
            init_mem[a] = 32'h5a5a0000 ^ (32'(a) * 32'h9e3779b1);
        end
    endtask

    task automatic run_pass(input logic [8*24-1:0] name, input pass_cfg_t cfg,
                            input logic stall, input int n_exp);
        int err_before;
        int done_before;
        int region;
        int lo;
        err_before  = errors;
        done_before = done_cnt;
        region      = NUM_LANES * int'(cfg.tile_len);
        lo          = int'(cfg.opsum_base);
        tests_run++;
        check_value(name, "pass_done pulses before start", passes, done_cnt);
        if (n_exp != region) begin
            $display("test %0s: golden file gives %0d opsum words but the pass writes %0d",
                     name, n_exp, region);
            errors++;
        end
        @(posedge clk);
        load_req <= 1'b1;
        stall_en <= stall;
        @(posedge clk);
        load_req     <= 1'b0;
        pass_start_i <= 1'b1;
        pass_cfg_i   <= cfg;
        @(posedge clk);
        pass_start_i <= 1'b0;
        pass_cfg_i   <= '0;  // config is latched on the start pulse
        @(posedge clk);
        while (!pass_done_o) @(posedge clk);
        stall_en <= 1'b0;
        repeat (4) @(posedge clk);  // window for a stray pulse while returning to IDLE
        check_value(name, "pass_done pulses after start", 1, done_cnt - done_before);
        passes++;
        for (int i = 0; i < n_exp && i < region; i++) begin
            check_value(name, $sformatf("opsum word at %0h", lo + i), exp_words[i],
                        mem[MW'(lo + i)]);
        end
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (a < lo || a >= lo + region) begin
                check_value(name, $sformatf("word at %0h outside opsum", a), init_mem[a], mem[a]);
            end
        end
        if (errors == err_before) begin
            $display("test %0s: ok", name);
        end else begin
            $display("test %0s: %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        logic [8*24-1:0]  tok, name;
        logic [8*256-1:0] line;
        logic [31:0]      wb, ib, pb, bb, ob, tl, bias, st, addr, cnt, word;
        pass_cfg_t        cfg;
        logic             stall;
        logic             bad;
        int               fd, n;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        passes       = 0;
        bad          = 1'b0;
        stall        = 1'b0;
        cfg          = '0;
        name         = '0;
        rst_n_i      <= 1'b0;
        pass_start_i <= 1'b0;
        pass_cfg_i   <= '0;
        load_req     <= 1'b0;
        stall_en     <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        fd = $fopen("token_engine_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open token_engine_golden.txt");
            errors++;
        end else begin
            while (!bad && $fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    n = $fgets(line, fd);  // drop the rest of a comment line
                end else if (tok == "test") begin
                    n = $fscanf(fd, "%s %h %h %h %h %h %h %h %h",
                                name, wb, ib, pb, bb, ob, tl, bias, st);
                    if (n != 9) bad = 1'b1;
                    cfg = '{weight_base: wb, ifmap_base: ib, ipsum_base: pb, bias_base: bb,
                            opsum_base: ob, tile_len: tl[7:0], is_bias: bias[0]};
                    stall = st[0];
                    fill_background();
                    cycle_limit = cycle_limit + 8 * (4 * NUM_LANES * int'(tl[7:0]) + 64);
                end else if (tok == "mem") begin
                    n = $fscanf(fd, "%h %h", addr, cnt);
                    if (n != 2) bad = 1'b1;
                    for (int i = 0; i < int'(cnt) && !bad; i++) begin
                        if ($fscanf(fd, "%h", word) != 1) bad = 1'b1;
                        init_mem[MW'(addr + 32'(i))] = word;
                    end
                end else if (tok == "exp") begin
                    n = $fscanf(fd, "%h", cnt);
                    if (n != 1 || cnt > 32'(MEM_WORDS)) bad = 1'b1;
                    for (int i = 0; i < int'(cnt) && !bad; i++) begin
                        if ($fscanf(fd, "%h", word) != 1) bad = 1'b1;
                        exp_words[i] = word;
                    end
                    if (!bad) run_pass(name, cfg, stall, int'(cnt));
                end else begin
                    bad = 1'b1;
                end
            end
            $fclose(fd);
        end
        if (bad) begin
            $display("golden file has a malformed record near '%0s'", tok);
            errors++;
        end
        errors = errors + range_errs;
        $display("tests run: %0d, failing tests: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- token_engine_golden.txt
# test <name> <weight_base> <ifmap_base> <ipsum_base> <bias_base> <opsum_base> <tile_len> <is_bias> <stall>
# mem <addr> <count> <words> preloads the GLB, exp <count> <words> from opsum_base runs the pass
# all numbers are hex
test bias_pass 0 10 30 8 40 2 1 0
mem 0 4 ff000002 00000003 12340005 00000007
mem 8 4 00000100 00000200 00000300 00000400
mem 10 8 0a 0b 1c 1d ab0000ff 01 10 20
exp 8 114 116 254 257 7fb 305 470 4e0
test ipsum_pass 0 10 20 8 40 3 0 0
mem 0 4 1 4 80 ff
mem 10 c 5 6 7 10 11 12 2 3 ff 1 2 ff
mem 20 c 1000 2000 3000 0 1 ffffffff 100 200 300 12345678 0 7
exp c 1005 2006 3007 40 45 47 200 380 8280 12345777 1fe fe08
test ipsum_stall 0 10 20 8 40 3 0 1
mem 0 4 1 4 80 ff
mem 10 c 5 6 7 10 11 12 2 3 ff 1 2 ff
mem 20 c 1000 2000 3000 0 1 ffffffff 100 200 300 12345678 0 7
exp c 1005 2006 3007 40 45 47 200 380 8280 12345777 1fe fe08
test tile_one 60 64 68 70 6c 1 0 0
mem 60 4 3 5 9 b
mem 64 4 11 22 33 44
mem 68 4 1 2 3 4
exp 4 34 ac 1ce 2f0
test tile_six 0 10 30 8 80 6 1 1
mem 0 4 1 2 3 4
mem 8 4 10000 20000 30000 40000
mem 10 18 1 2 3 4 5 6 10 20 30 40 50 60
  a b c d e f f0 f1 f2 f3 f4 f5
exp 18 10001 10002 10003 10004 10005 10006 20020 20040 20060 20080 200a0 200c0
  3001e 30021 30024 30027 3002a 3002d 403c0 403c4 403c8 403cc 403d0 403d4

//--- src.f
te_pkg.sv
lane_fifo.sv
pass_controller.sv
weight_loader.sv
fifo_fill_ctrl.sv
mac_lane_array.sv
opsum_drain.sv
glb_arbiter.sv
token_engine.sv
tb_token_engine.sv

//--- run.sh
#!/bin/sh
# build and run the token engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_token_engine -o tb_token_engine
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_token_engine > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
